//--- Makefile
# Verilator lint and simulation of the TLV pass-through core.
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= decomp_stub_core.f
RTL_TOP   ?= decomp_stub_core
TB_TOP    ?= tb_decomp_stub_core
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation completed successfully" $(LOG) || \
		{ echo "FAIL: run ended without a result line, see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- decomp_stub_core.f
+incdir+verification
logic/stream_pkg.sv
logic/tlv_pkg.sv
logic/axis_beat_if.sv
logic/stream_reg_slice.sv
logic/tlv_frame_tracker.sv
logic/decomp_stub_core.sv
verification/tb_decomp_stub_core.sv

//--- logic/axis_beat_if.sv
//****************************************
// One ready/valid stream beat. The producer takes
// the source modport, the consumer the sink modport,
// and passive observers the monitor modport.
//****************************************

`timescale 1ns/1ps

interface axis_beat_if #(
   parameter int DATA_W = stream_pkg::DATA_W
);

   logic                          tvalid;
   logic                          tready;
   logic [DATA_W-1:0]             tdata;
   logic [stream_pkg::STRB_W-1:0] tstrb;
   logic [stream_pkg::USER_W-1:0] tuser;  // sot in bit 0, eot in bit 1.

   // A beat moves on a rising edge with tvalid and tready both high.
   modport source (
      output tvalid,
      output tdata,
      output tstrb,
      output tuser,
      input  tready
   );

   modport sink (
      input  tvalid,
      input  tdata,
      input  tstrb,
      input  tuser,
      output tready
   );

   modport monitor (
      input tvalid,
      input tready,
      input tdata,
      input tstrb,
      input tuser
   );

endinterface

//--- logic/decomp_stub_core.sv
//****************************************
// Pass-through TLV stream engine. Inbound beats leave
// unchanged through a register slice while a tracker
// reports one scheduler update per DATA TLV.
//****************************************

`timescale 1ns/1ps

module decomp_stub_core #(
   parameter int DATA_W  = stream_pkg::DATA_W,
   parameter int COUNT_W = stream_pkg::COUNT_W
) (
   input  logic                            clk,
   input  logic                            rst_n,

   // inbound stream.
   input  logic                            ib_tvalid,
   output logic                            ib_tready,
   input  logic [DATA_W-1:0]               ib_tdata,
   input  logic [stream_pkg::STRB_W-1:0]   ib_tstrb,
   input  logic [stream_pkg::USER_W-1:0]   ib_tuser,

   // outbound stream.
   output logic                            ob_tvalid,
   input  logic                            ob_tready,
   output logic [DATA_W-1:0]               ob_tdata,
   output logic [stream_pkg::STRB_W-1:0]   ob_tstrb,
   output logic [stream_pkg::USER_W-1:0]   ob_tuser,

   // scheduler update.
   output logic                            sched_valid,
   output logic [stream_pkg::HANDLE_W-1:0] sched_handle,
   output logic [stream_pkg::FRAME_W-1:0]  sched_frame_num,
   output logic [stream_pkg::ENG_W-1:0]    sched_eng_id,
   output logic [stream_pkg::SEQ_W-1:0]    sched_seq_num,
   output logic [COUNT_W-1:0]              sched_bytes,
   output logic                            sched_last
);

   axis_beat_if #(.DATA_W(DATA_W)) ib_beat ();
   axis_beat_if #(.DATA_W(DATA_W)) ob_beat ();

   //****************************************
   // port to interface wiring
   //****************************************
   assign ib_beat.tvalid = ib_tvalid;
   assign ib_beat.tdata  = ib_tdata;
   assign ib_beat.tstrb  = ib_tstrb;
   assign ib_beat.tuser  = ib_tuser;
   assign ib_tready      = ib_beat.tready;

   assign ob_tvalid      = ob_beat.tvalid;
   assign ob_tdata       = ob_beat.tdata;
   assign ob_tstrb       = ob_beat.tstrb;
   assign ob_tuser       = ob_beat.tuser;
   assign ob_beat.tready = ob_tready;

   //****************************************
   // data path
   //****************************************
   stream_reg_slice #(
      .DATA_W (DATA_W)
   ) u_slice (
      .clk   (clk),
      .rst_n (rst_n),
      .up    (ib_beat.sink),
      .dn    (ob_beat.source)
   );

   //****************************************
   // scheduler bookkeeping
   //****************************************
   tlv_frame_tracker #(
      .COUNT_W (COUNT_W)
   ) u_tracker (
      .clk             (clk),
      .rst_n           (rst_n),
      .mon             (ib_beat.monitor),  // sees only accepted beats.
      .sched_valid     (sched_valid),
      .sched_handle    (sched_handle),
      .sched_frame_num (sched_frame_num),
      .sched_eng_id    (sched_eng_id),
      .sched_seq_num   (sched_seq_num),
      .sched_bytes     (sched_bytes),
      .sched_last      (sched_last)
   );

endmodule

//--- logic/stream_pkg.sv
//****************************************
// Widths shared by the TLV stream path and the
// scheduler-update outputs. Referenced by scoped name
// from the RTL and from the testbench.
//****************************************

package stream_pkg;

   //****************************************
   // stream beat
   //****************************************
   parameter int DATA_W   = 64;  // tdata width.
   parameter int STRB_W   = 8;   // one strobe per byte.
   parameter int USER_W   = 2;   // sot and eot flags.

   //****************************************
   // scheduler update
   //****************************************
   parameter int HANDLE_W = 16;  // rqe scheduler handle.
   parameter int FRAME_W  = 11;  // tlv frame number.
   parameter int ENG_W    = 4;   // engine id.
   parameter int SEQ_W    = 8;   // sequence number.

   // Default width of the DATA byte counter. One update
   // reports the same count for bytes in, bytes out and basis.
   parameter int COUNT_W  = 24;

endpackage

//--- logic/stream_reg_slice.sv
//****************************************
// Two-entry register slice for a ready/valid stream.
// Keeps one beat per cycle while downstream is ready
// and catches the beat in flight when ready drops.
//****************************************

`timescale 1ns/1ps

module stream_reg_slice #(
   parameter int DATA_W = stream_pkg::DATA_W
) (
   input  logic      clk,
   input  logic      rst_n,
   axis_beat_if.sink up,
   axis_beat_if.source dn
);

   localparam int PAY_W = DATA_W + stream_pkg::STRB_W + stream_pkg::USER_W;

   logic             main_valid;
   logic             skid_valid;
   logic [PAY_W-1:0] main_pay;
   logic [PAY_W-1:0] skid_pay;
   logic [PAY_W-1:0] up_pay;
   logic             up_xfer;
   logic             main_load;

   //****************************************
   // handshake
   //****************************************
   assign up_pay  = {up.tdata, up.tstrb, up.tuser};
   assign up_xfer = up.tvalid & up.tready;

   // ready only depends on occupancy, never on dn.tready.
   assign up.tready = !skid_valid;

   // main register is empty or drains on this edge.
   assign main_load = dn.tready | !main_valid;

   //****************************************
   // occupancy
   //****************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
      end else if (main_load) begin
         main_valid <= skid_valid | up_xfer;  // skid goes first.
         skid_valid <= 1'b0;
      end else if (up_xfer) begin
         skid_valid <= 1'b1;                  // park the beat in flight.
      end
   end

   //****************************************
   // payload
   //****************************************
   always_ff @(posedge clk) begin
      if (main_load) begin
         if (skid_valid) begin
            main_pay <= skid_pay;
         end else if (up_xfer) begin
            main_pay <= up_pay;
         end
      end
      if (!main_load && up_xfer) begin
         skid_pay <= up_pay;
      end
   end

   assign dn.tvalid = main_valid;
   assign dn.tdata  = main_pay[PAY_W-1 -: DATA_W];
   assign dn.tstrb  = main_pay[stream_pkg::USER_W +: stream_pkg::STRB_W];
   assign dn.tuser  = main_pay[stream_pkg::USER_W-1:0];

   //****************************************
   // checks
   //****************************************
   // a stalled outbound beat keeps its payload until taken.
   a_dn_hold : assert property (
      @(posedge clk) disable iff (!rst_n)
      dn.tvalid && !dn.tready |=>
         dn.tvalid && $stable({dn.tdata, dn.tstrb, dn.tuser})
   );

endmodule

//--- logic/tlv_frame_tracker.sv
//****************************************
// Watches accepted inbound beats, keeps the fields of
// the latest RQE and counts DATA bytes. Emits one
// scheduler-update pulse at the end of each DATA TLV.
//****************************************

`timescale 1ns/1ps

module tlv_frame_tracker #(
   parameter int COUNT_W = stream_pkg::COUNT_W
) (
   input  logic                            clk,
   input  logic                            rst_n,
   axis_beat_if.monitor                    mon,
   output logic                            sched_valid,
   output logic [stream_pkg::HANDLE_W-1:0] sched_handle,
   output logic [stream_pkg::FRAME_W-1:0]  sched_frame_num,
   output logic [stream_pkg::ENG_W-1:0]    sched_eng_id,
   output logic [stream_pkg::SEQ_W-1:0]    sched_seq_num,
   output logic [COUNT_W-1:0]              sched_bytes,
   output logic                            sched_last
);

   logic                            tap_valid;
   logic [stream_pkg::DATA_W-1:0]   tap_data;
   logic [stream_pkg::STRB_W-1:0]   tap_strb;
   logic [stream_pkg::USER_W-1:0]   tap_user;
   logic                            tap_sot;
   logic                            tap_eot;
   logic                            tap_is_rqe;
   logic                            tap_is_data;
   logic [COUNT_W-1:0]              beat_bytes;
   logic                            rqe_word_1;
   logic                            in_data;
   logic                            pending;
   logic [COUNT_W-1:0]              byte_cnt;
   logic [stream_pkg::HANDLE_W-1:0] handle;
   logic [stream_pkg::FRAME_W-1:0]  frame_num;
   logic [stream_pkg::ENG_W-1:0]    eng_id;
   logic [stream_pkg::SEQ_W-1:0]    seq_num;

   //****************************************
   // accepted beat tap
   //****************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tap_valid <= 1'b0;
      end else begin
         tap_valid <= mon.tvalid & mon.tready;
      end
   end

   always_ff @(posedge clk) begin
      if (mon.tvalid && mon.tready) begin
         tap_data <= mon.tdata;
         tap_strb <= mon.tstrb;
         tap_user <= mon.tuser;
      end
   end

   assign tap_sot     = tap_valid & tap_user[tlv_pkg::SOT_BIT];
   assign tap_eot     = tap_valid & tap_user[tlv_pkg::EOT_BIT];
   assign tap_is_rqe  = tlv_pkg::tlv_type_e'(tap_data[tlv_pkg::TYPE_LSB +: tlv_pkg::TYPE_W])
                        == tlv_pkg::TLV_RQE;
   assign tap_is_data = tlv_pkg::tlv_type_e'(tap_data[tlv_pkg::TYPE_LSB +: tlv_pkg::TYPE_W])
                        == tlv_pkg::TLV_DATA;
   assign beat_bytes  = COUNT_W'($countones(tap_strb));

   //****************************************
   // rqe capture and data byte count
   //****************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rqe_word_1 <= 1'b0;
         in_data    <= 1'b0;
         pending    <= 1'b0;
         byte_cnt   <= '0;
         handle     <= '0;
         frame_num  <= '0;
         eng_id     <= '0;
         seq_num    <= '0;
      end else begin
         pending <= 1'b0;

         if (rqe_word_1 && tap_valid) begin
            handle     <= tap_data[tlv_pkg::HANDLE_LSB +: stream_pkg::HANDLE_W];
            rqe_word_1 <= 1'b0;
         end
         if (tap_sot && tap_is_rqe) begin
            rqe_word_1 <= 1'b1;  // handle is in the next beat.
            frame_num  <= tap_data[tlv_pkg::FRAME_LSB +: stream_pkg::FRAME_W];
            eng_id     <= tap_data[tlv_pkg::ENG_LSB +: stream_pkg::ENG_W];
            seq_num    <= tap_data[tlv_pkg::SEQ_LSB +: stream_pkg::SEQ_W];
         end

         if (in_data && tap_valid) begin
            byte_cnt <= byte_cnt + beat_bytes;
         end
         if (in_data && tap_eot) begin
            in_data <= 1'b0;
            pending <= 1'b1;
         end
         // header beat itself carries no payload bytes.
         if (tap_sot && tap_is_data) begin
            byte_cnt <= '0;
            in_data  <= 1'b1;
         end
      end
   end

   //****************************************
   // scheduler update
   //****************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sched_valid     <= 1'b0;
         sched_handle    <= '0;
         sched_frame_num <= '0;
         sched_eng_id    <= '0;
         sched_seq_num   <= '0;
         sched_bytes     <= '0;
         sched_last      <= 1'b0;
      end else begin
         sched_valid <= pending;
         if (pending) begin
            sched_handle    <= handle;
            sched_frame_num <= frame_num;
            sched_eng_id    <= eng_id;
            sched_seq_num   <= seq_num;
            sched_bytes     <= byte_cnt;  // in, out and basis are equal.
            sched_last      <= 1'b1;
         end
      end
   end

   a_sched_pulse : assert property (
      @(posedge clk) disable iff (!rst_n)
      sched_valid |=> !sched_valid
   );

endmodule

//--- logic/tlv_pkg.sv
//****************************************
// TLV type codes and field positions inside a
// 64-bit TLV word. Used by the frame tracker
// and by the testbench to build stimulus.
//****************************************

package tlv_pkg;

   //****************************************
   // type byte, data bits 7..0 of a header beat
   //****************************************
   parameter int TYPE_LSB = 0;
   parameter int TYPE_W   = 8;

   typedef enum logic [TYPE_W-1:0] {
      TLV_RQE  = 8'd1,   // request entry.
      TLV_CMD  = 8'd2,
      TLV_KEY  = 8'd3,
      TLV_PHD  = 8'd4,
      TLV_PFD  = 8'd5,
      TLV_FTR  = 8'd6,   // frame footer.
      TLV_CQE  = 8'd7,
      TLV_DATA = 8'd8    // payload, counted.
   } tlv_type_e;

   //****************************************
   // rqe first word
   //****************************************
   parameter int FRAME_LSB = 32;  // bits 42..32.
   parameter int ENG_LSB   = 24;  // bits 27..24.
   parameter int SEQ_LSB   = 16;  // bits 23..16.

   // rqe second word, bits 47..32.
   parameter int HANDLE_LSB = 32;

   //****************************************
   // tuser flags
   //****************************************
   parameter int SOT_BIT = 0;  // start of tlv.
   parameter int EOT_BIT = 1;  // end of tlv.

endpackage

//--- verification/tb_tasks.svh
//****************************************
// Stimulus tasks, reference functions and the
// check task. Included inside the testbench module.
//****************************************

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string what, input beat_t expected, input beat_t actual);
   checks++;
   if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
   end
endtask

task automatic report_error(input string msg);
   errors++;
   $display("%s: %s", test_name, msg);
endtask

// number of valid bytes in one beat.
function automatic int unsigned strobe_count(input strb_t strb);
   int unsigned n;
   n = 0;
   for (int i = 0; i < stream_pkg::STRB_W; i++) begin
      if (strb[i]) n++;
   end
   return n;
endfunction

// sched record from the latest rqe words and the data byte total.
function automatic rec_t ref_sched(input data_t w0, input data_t w1, input int unsigned nbytes);
   return {w1[tlv_pkg::HANDLE_LSB +: stream_pkg::HANDLE_W],
           w0[tlv_pkg::FRAME_LSB +: stream_pkg::FRAME_W],
           w0[tlv_pkg::ENG_LSB +: stream_pkg::ENG_W],
           w0[tlv_pkg::SEQ_LSB +: stream_pkg::SEQ_W],
           nbytes[stream_pkg::COUNT_W-1:0], 1'b1};
endfunction

task automatic send_beat(input data_t data, input strb_t strb, input user_t user,
                         output int unsigned seen);
   ib_tvalid <= 1'b1;
   ib_tdata  <= data;
   ib_tstrb  <= strb;
   ib_tuser  <= user;
   @(negedge clk);
   while (!ib_tready) begin
      @(negedge clk);
   end
   seen = cycle;
   @(posedge clk);                          // beat moves on this edge.
   exp_beats.push_back({data, strb, user});
endtask

task automatic send_rqe(input int unsigned frame, eng, seq, handle);
   int unsigned seen;
   rqe_w0 = {$urandom, $urandom};
   rqe_w0[tlv_pkg::TYPE_LSB +: tlv_pkg::TYPE_W]    = tlv_pkg::TLV_RQE;
   rqe_w0[tlv_pkg::FRAME_LSB +: stream_pkg::FRAME_W] = frame[stream_pkg::FRAME_W-1:0];
   rqe_w0[tlv_pkg::ENG_LSB +: stream_pkg::ENG_W]     = eng[stream_pkg::ENG_W-1:0];
   rqe_w0[tlv_pkg::SEQ_LSB +: stream_pkg::SEQ_W]     = seq[stream_pkg::SEQ_W-1:0];
   rqe_w1 = {$urandom, $urandom};
   rqe_w1[tlv_pkg::HANDLE_LSB +: stream_pkg::HANDLE_W] = handle[stream_pkg::HANDLE_W-1:0];
   send_beat(rqe_w0, '1, USER_SOT, seen);
   send_beat(rqe_w1, '1, USER_EOT, seen);
endtask

task automatic send_data(input int n, input bit full);
   int unsigned seen;
   int unsigned nbytes;
   data_t       word;
   strb_t       strb;
   nbytes = 0;
   word = {$urandom, $urandom};
   word[tlv_pkg::TYPE_LSB +: tlv_pkg::TYPE_W] = tlv_pkg::TLV_DATA;
   send_beat(word, '1, USER_SOT, seen);       // header bytes not counted.
   for (int i = 0; i < n; i++) begin
      strb = full ? '1 : strb_t'($urandom);
      nbytes += strobe_count(strb);
      send_beat({$urandom, $urandom}, strb, (i == n - 1) ? USER_EOT : USER_MID, seen);
   end
   exp_sched.push_back(ref_sched(rqe_w0, rqe_w1, nbytes));
   exp_due.push_back(seen + SCHED_LAG);
endtask

task automatic send_other(input tlv_pkg::tlv_type_e kind, input int n);
   int unsigned seen;
   data_t       word;
   word = {$urandom, $urandom};
   word[tlv_pkg::TYPE_LSB +: tlv_pkg::TYPE_W] = kind;
   send_beat(word, '1, USER_SOT, seen);
   for (int i = 1; i < n; i++) begin
      send_beat({$urandom, $urandom}, strb_t'($urandom), (i == n - 1) ? USER_EOT : USER_MID,
                seen);
   end
endtask

task automatic start_test(input string name);
   test_name = name;
   errs_at_start = errors;
   tests_run++;
endtask

task automatic finish_test();
   ib_tvalid <= 1'b0;
   while (exp_beats.size() != 0 || exp_sched.size() != 0) begin
      @(posedge clk);
   end
   repeat (6) @(posedge clk);               // room for a stray pulse.
   if (errors == errs_at_start) begin
      $display("test %-18s ok", test_name);
   end else begin
      tests_failed++;
      $display("test %-18s %0d error(s)", test_name, errors - errs_at_start);
   end
endtask

`endif

//--- verification/tb_decomp_stub_core.sv
//****************************************
// Testbench for the TLV pass-through core. Sends RQE,
// DATA and other TLVs, checks the outbound stream and
// the scheduler updates against reference values.
//****************************************

`timescale 1ns/1ps

module tb_decomp_stub_core;

   typedef logic [stream_pkg::DATA_W-1:0] data_t;
   typedef logic [stream_pkg::STRB_W-1:0] strb_t;
   typedef logic [stream_pkg::USER_W-1:0] user_t;

   localparam int BEAT_W = stream_pkg::DATA_W + stream_pkg::STRB_W + stream_pkg::USER_W;
   localparam int REC_W  = stream_pkg::HANDLE_W + stream_pkg::FRAME_W + stream_pkg::ENG_W +
                           stream_pkg::SEQ_W + stream_pkg::COUNT_W + 1;
   typedef logic [BEAT_W-1:0] beat_t;  // also the widest compared value.
   typedef logic [REC_W-1:0]  rec_t;

   localparam user_t USER_SOT = user_t'(1 << tlv_pkg::SOT_BIT);
   localparam user_t USER_EOT = user_t'(1 << tlv_pkg::EOT_BIT);
   localparam user_t USER_MID = '0;

   localparam int SEED      = 95441;
   localparam int SCHED_LAG = 3;   // high after edge N+2, seen three negedges on.
   localparam int N_FULL    = 4;
   localparam int N_FIELD   = 3;
   localparam int N_PART    = 5;
   localparam int PART_TLVS = 3;
   localparam int N_BP      = 6;
   localparam int BP_TLVS   = 4;
   localparam int OTHER_LEN = 3;
   localparam int TOTAL_BEATS = (3 + N_FULL) + (3 + N_FIELD) + PART_TLVS * (3 + N_PART) +
                                BP_TLVS * (3 + N_BP + OTHER_LEN) + 3 * OTHER_LEN;
   localparam int TIMEOUT_CYCLES = 4 * TOTAL_BEATS + 200;

   logic clk;
   logic rst_n;
   logic ib_tvalid, ib_tready, ob_tvalid, ob_tready;
   data_t ib_tdata, ob_tdata;
   strb_t ib_tstrb, ob_tstrb;
   user_t ib_tuser, ob_tuser;
   logic sched_valid, sched_last;
   logic [stream_pkg::HANDLE_W-1:0] sched_handle;
   logic [stream_pkg::FRAME_W-1:0]  sched_frame_num;
   logic [stream_pkg::ENG_W-1:0]    sched_eng_id;
   logic [stream_pkg::SEQ_W-1:0]    sched_seq_num;
   logic [stream_pkg::COUNT_W-1:0]  sched_bytes;

   beat_t exp_beats[$], act_beats[$];
   rec_t  exp_sched[$], act_sched[$];
   int unsigned exp_due[$], act_cyc[$];
   beat_t want_beat, got_beat;
   rec_t  want_rec, got_rec;
   int unsigned want_cyc, got_cyc;
   data_t rqe_w0, rqe_w1;              // latest rqe sent.
   int unsigned cycle = 0;
   bit bp_on, check_lat;
   string test_name = "startup";
   int tests_run = 0, tests_failed = 0, checks = 0, errors = 0, errs_at_start = 0;

   `include "tb_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   decomp_stub_core #(
      .DATA_W  (stream_pkg::DATA_W),
      .COUNT_W (stream_pkg::COUNT_W)
   ) UUT (
      .clk (clk), .rst_n (rst_n),
      .ib_tvalid (ib_tvalid), .ib_tready (ib_tready), .ib_tdata (ib_tdata),
      .ib_tstrb (ib_tstrb), .ib_tuser (ib_tuser),
      .ob_tvalid (ob_tvalid), .ob_tready (ob_tready), .ob_tdata (ob_tdata),
      .ob_tstrb (ob_tstrb), .ob_tuser (ob_tuser),
      .sched_valid (sched_valid), .sched_handle (sched_handle),
      .sched_frame_num (sched_frame_num), .sched_eng_id (sched_eng_id),
      .sched_seq_num (sched_seq_num), .sched_bytes (sched_bytes), .sched_last (sched_last)
   );

   // outbound ready, random while back-pressure is on.
   initial begin
      ob_tready <= 1'b1;
      forever begin
         @(posedge clk);
         ob_tready <= bp_on ? ($urandom_range(0, 2) != 0) : 1'b1;
      end
   end

   //****************************************
   // capture and compare
   //****************************************
   always @(negedge clk) begin
      if (rst_n) begin
         if (ob_tvalid && ob_tready) act_beats.push_back({ob_tdata, ob_tstrb, ob_tuser});
         if (sched_valid) begin
            act_sched.push_back({sched_handle, sched_frame_num, sched_eng_id, sched_seq_num,
                                 sched_bytes, sched_last});
            act_cyc.push_back(cycle);
         end
      end
      while (act_beats.size() != 0) begin
         got_beat = act_beats.pop_front();
         if (exp_beats.size() == 0) begin
            report_error($sformatf("outbound beat %h that was never sent", got_beat));
         end else begin
            want_beat = exp_beats.pop_front();
            check_value("ob beat", want_beat, got_beat);
         end
      end
      while (act_sched.size() != 0) begin
         got_rec = act_sched.pop_front();
         got_cyc = act_cyc.pop_front();
         if (exp_sched.size() == 0) begin
            report_error($sformatf("scheduler update %h with no DATA TLV ended", got_rec));
         end else begin
            want_rec = exp_sched.pop_front();
            want_cyc = exp_due.pop_front();
            check_value("sched record", beat_t'(want_rec), beat_t'(got_rec));
            if (check_lat) check_value("sched cycle", beat_t'(want_cyc), beat_t'(got_cyc));
         end
      end
   end

   initial begin
      wait (cycle >= TIMEOUT_CYCLES);
      $display("timeout after %0d cycles in %s, stream stopped moving", cycle, test_name);
      $display("Simulation failed");
      $finish;
   end

   //****************************************
   // test sequence
   //****************************************
   initial begin
      void'($urandom(SEED));
      rst_n     <= 1'b0;
      ib_tvalid <= 1'b0;
      ib_tdata  <= '0;
      ib_tstrb  <= '0;
      ib_tuser  <= '0;
      bp_on     <= 1'b0;
      check_lat <= 1'b1;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      start_test("reset_state");
      @(negedge clk);
      check_value("ob_tvalid", '0, beat_t'(ob_tvalid));
      check_value("sched_valid", '0, beat_t'(sched_valid));
      check_value("ib_tready", beat_t'(1'b1), beat_t'(ib_tready));
      @(posedge clk);
      finish_test();

      start_test("full_strobe_pass");
      send_rqe('h012, 'h3, 'h01, 'h1234);
      send_data(N_FULL, 1'b1);
      finish_test();

      start_test("rqe_fields");
      send_rqe('h5a3, 'hc, 'h7e, 'hbeef);
      send_data(N_FIELD, 1'b1);
      finish_test();

      start_test("partial_strobe");
      repeat (PART_TLVS) begin
         send_rqe($urandom, $urandom, $urandom, $urandom);
         send_data(N_PART, 1'b0);
      end
      finish_test();

      start_test("back_pressure");
      bp_on     <= 1'b1;
      check_lat <= 1'b0;
      repeat (BP_TLVS) begin
         send_rqe($urandom, $urandom, $urandom, $urandom);
         send_data(N_BP, 1'b0);
         send_other(tlv_pkg::TLV_KEY, OTHER_LEN);
      end
      finish_test();
      bp_on     <= 1'b0;
      check_lat <= 1'b1;

      start_test("other_types");
      send_other(tlv_pkg::TLV_CMD, OTHER_LEN);
      send_other(tlv_pkg::TLV_FTR, OTHER_LEN);
      send_other(tlv_pkg::TLV_CQE, OTHER_LEN);
      finish_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
